// File: Makefile
# Verilator build and run of the receive path testbench
VERILATOR ?= verilator
TOP       ?= dzRxTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

FAIL_MSG := Simulation finished: FAIL
PASS_MSG := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the result"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Run reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Run ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dzCsr.sv
// Receive-side control/status register; holds MSE and SAE, issues CLR, reads back status
`timescale 1ns/1ps
`default_nettype none

module dzCsr import dzPkg::*; (
   input  wire         clk,
   input  wire         rst,
   input  wire         csrWrite,
   input  wire  [15:0] csrWdata,
   input  wire         rbufRdone,
   input  wire         rbufSa,
   output logic        csrMse,
   output logic        csrSae,
   output logic        clr,
   output logic [15:0] csrRdata
);

   //////////////////////////////////////////////////
   // Writable bits and clear pulse
   //////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         csrMse <= 1'b0;
         csrSae <= 1'b0;
         clr    <= 1'b0;
      end
      else
      begin
         // One clock wide, drops by itself
         clr <= csrWrite & csrWdata[csrClrBit];
         if (csrWrite)
         begin
            csrMse <= csrWdata[csrMseBit];
            csrSae <= csrWdata[csrSaeBit];
         end
      end
   end

   //////////////////////////////////////////////////
   // Readback
   //////////////////////////////////////////////////

   // Unused positions read as zero
   always_comb
   begin
      csrRdata = '0;
      csrRdata[csrMseBit]   = csrMse;
      csrRdata[csrRdoneBit] = rbufRdone;
      csrRdata[csrSaeBit]   = csrSae;
      csrRdata[csrSaBit]    = rbufSa;
   end

endmodule

`default_nettype wire

// File: dzPkg.sv
// Shared constants and types for the DZ-11 style receive path; import with dzPkg::*
`default_nettype none

package dzPkg;

   //////////////////////////////////////////////////
   // Line and silo geometry
   //////////////////////////////////////////////////

   localparam int numLines   = 8;
   localparam int scanBits   = 3;
   localparam int siloDepth  = 64;
   localparam int ptrBits    = 6;
   // Depth counter needs one more bit than the pointers
   localparam int depthBits  = ptrBits + 1;
   localparam int alarmLevel = 16;
   localparam int alarmBits  = 5;

   // Serial bit timing, in clocks
   localparam int clksPerBit = 16;
   localparam int tickBits   = $clog2(clksPerBit);

   //////////////////////////////////////////////////
   // RBUF word layout
   //////////////////////////////////////////////////

   localparam int rbufDvalBit = 15;
   localparam int rbufOvreBit = 14;
   localparam int rbufFerrBit = 13;
   localparam int rbufPerrBit = 12;
   localparam int rbufLineLsb = 8;

   // CSR layout
   localparam int csrClrBit   = 4;
   localparam int csrMseBit   = 5;
   localparam int csrRdoneBit = 7;
   localparam int csrSaeBit   = 12;
   localparam int csrSaBit    = 13;

   // Receiver FSM
   typedef enum logic [1:0] {rxIdle, rxStart, rxData, rxStop} rxState_t;

endpackage

`default_nettype wire

// File: dzRbuf.sv
// Receive silo and RBUF register; empties the scanned receiver and serves host reads
`timescale 1ns/1ps
`default_nettype none

module dzRbuf import dzPkg::*; (
   input  wire                 clk,
   input  wire                 rst,
   input  wire                 clr,
   input  wire                 csrMse,
   input  wire                 csrSae,
   input  wire  [scanBits-1:0] scan,
   input  wire  [15:0]         uartRxData,
   input  wire                 uartRxFull,
   output logic [numLines-1:0] uartRxClr,
   input  wire                 rbufRead,
   output logic                rbufRdone,
   output logic                rbufSa,
   output logic [15:0]         regRbuf
);

   logic                 siloWr;
   logic                 siloRd;
   logic                 readDly;
   logic                 rdDly;
   logic                 wrDly;
   logic [depthBits-1:0] depth;
   logic [ptrBits-1:0]   rdPtr;
   logic [ptrBits-1:0]   wrPtr;
   logic [ptrBits-1:0]   wrAddr;
   logic                 siloEmpty;
   logic                 siloFull;
   logic                 rdGo;
   logic                 overrun;
   logic                 rbufDval;
   logic                 rbufOvre;
   logic [13:0]          headData;
   logic [alarmBits-1:0] saCount;
   logic [14:0]          silo [siloDepth];

   //////////////////////////////////////////////////
   // Receiver side
   //////////////////////////////////////////////////

   // Store whenever the scanned line holds a character
   assign siloWr = csrMse & uartRxFull;

   // Clear only the line being stored
   always_comb
   begin
      uartRxClr = '0;
      if (siloWr)
         uartRxClr[scan] = 1'b1;
   end

   //////////////////////////////////////////////////
   // Host read, trailing edge
   //////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         readDly <= 1'b0;
         rdDly   <= 1'b0;
         wrDly   <= 1'b0;
      end
      else
      begin
         readDly <= rbufRead;
         // Status follows once pointers have moved
         rdDly   <= siloRd;
         wrDly   <= siloWr;
      end
   end

   // Host has finished sampling rbufData
   assign siloRd = readDly & ~rbufRead;

   //////////////////////////////////////////////////
   // Pointers and depth
   //////////////////////////////////////////////////

   assign siloEmpty = (depth == '0);
   assign siloFull  = (depth == depthBits'(siloDepth));
   assign rdGo      = siloRd & ~siloEmpty;
   // Full silo with no read this cycle
   assign overrun   = siloWr & siloFull & ~rdGo;
   // Overrun replaces the newest entry
   assign wrAddr    = overrun ? wrPtr - 1'b1 : wrPtr;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         depth <= '0;
         rdPtr <= '0;
         wrPtr <= '0;
      end
      else if (clr)
      begin
         depth <= '0;
         rdPtr <= '0;
         wrPtr <= '0;
      end
      else
      begin
         if (rdGo)
            rdPtr <= rdPtr + 1'b1;
         if (siloWr && !overrun)
            wrPtr <= wrPtr + 1'b1;
         // Read and write together leave depth alone
         case ({siloWr & ~overrun, rdGo})
            2'b10:   depth <= depth + 1'b1;
            2'b01:   depth <= depth - 1'b1;
            default: depth <= depth;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Silo memory
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (siloWr)
         silo[wrAddr] <= {overrun, uartRxData[rbufOvreBit-1:0]};
      // Head entry, one clock behind the read pointer
      headData <= silo[rdPtr][rbufOvreBit-1:0];
   end

   //////////////////////////////////////////////////
   // DVAL and OVRE
   //////////////////////////////////////////////////

   // Two clocks after a write, one after a read
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         rbufDval <= 1'b0;
         rbufOvre <= 1'b0;
      end
      else if (clr)
      begin
         rbufDval <= 1'b0;
         rbufOvre <= 1'b0;
      end
      else if (rdDly | wrDly)
      begin
         rbufDval <= ~siloEmpty;
         rbufOvre <= ~siloEmpty & silo[rdPtr][rbufOvreBit];
      end
   end

   //////////////////////////////////////////////////
   // Silo alarm
   //////////////////////////////////////////////////

   // Counts writes, not depth; saturates at the alarm level
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         saCount <= '0;
         rbufSa  <= 1'b0;
      end
      else if (clr || siloRd || !csrSae)
      begin
         saCount <= '0;
         rbufSa  <= 1'b0;
      end
      else if (siloWr)
      begin
         if (saCount != alarmBits'(alarmLevel))
            saCount <= saCount + 1'b1;
         if (saCount == alarmBits'(alarmLevel - 1))
            rbufSa <= 1'b1;
      end
   end

   // Status and register outputs
   assign rbufRdone = ~siloEmpty;
   assign regRbuf   = {rbufDval, rbufOvre, headData};

endmodule

`default_nettype wire

// File: dzRx.sv
// Top level of the eight-line receive path; connects receivers, scanner, CSR and silo
`timescale 1ns/1ps
`default_nettype none

module dzRx import dzPkg::*; (
   input  wire                 clk,
   input  wire                 rst,
   input  wire  [numLines-1:0] rxSerial,
   input  wire                 csrWrite,
   input  wire  [15:0]         csrWdata,
   output logic [15:0]         csrRdata,
   input  wire                 rbufRead,
   output logic [15:0]         rbufData,
   output logic                rbufRdone,
   output logic                rbufSa
);

   logic [numLines*8-1:0] rxChar;
   logic [numLines-1:0]   rxFerr;
   logic [numLines-1:0]   rxFull;
   logic [numLines-1:0]   rxClr;
   logic [scanBits-1:0]   scan;
   logic [15:0]           uartRxData;
   logic                  uartRxFull;
   logic                  csrMse;
   logic                  csrSae;
   logic                  clr;

   //////////////////////////////////////////////////
   // Serial receivers
   //////////////////////////////////////////////////

   for (genvar i = 0; i < numLines; i++)
   begin : g_line
      dzUartRx i_uartRx (
         .clk      (clk),
         .rst      (rst),
         .rxSerial (rxSerial[i]),
         .rxClr    (rxClr[i]),
         .rxChar   (rxChar[i*8 +: 8]),
         .rxFerr   (rxFerr[i]),
         .rxFull   (rxFull[i])
      );
   end

   // Scanner, CSR, silo
   dzScanner i_scanner (
      .clk        (clk),
      .rst        (rst),
      .csrMse     (csrMse),
      .rxChar     (rxChar),
      .rxFerr     (rxFerr),
      .rxFull     (rxFull),
      .scan       (scan),
      .uartRxData (uartRxData),
      .uartRxFull (uartRxFull)
   );

   dzCsr i_csr (
      .clk       (clk),
      .rst       (rst),
      .csrWrite  (csrWrite),
      .csrWdata  (csrWdata),
      .rbufRdone (rbufRdone),
      .rbufSa    (rbufSa),
      .csrMse    (csrMse),
      .csrSae    (csrSae),
      .clr       (clr),
      .csrRdata  (csrRdata)
   );

   dzRbuf i_rbuf (
      .clk        (clk),
      .rst        (rst),
      .clr        (clr),
      .csrMse     (csrMse),
      .csrSae     (csrSae),
      .scan       (scan),
      .uartRxData (uartRxData),
      .uartRxFull (uartRxFull),
      .uartRxClr  (rxClr),
      .rbufRead   (rbufRead),
      .rbufRdone  (rbufRdone),
      .rbufSa     (rbufSa),
      .regRbuf    (rbufData)
   );

endmodule

`default_nettype wire

// File: dzRxTb.sv
// Directed testbench for the eight-line receive path; top module for the Verilator build
`timescale 1ns/1ps
`default_nettype none

module dzRxTb
   import dzPkg::*;
();

   // About 110 frames of 12 bit times plus reads, with margin
   localparam int watchdogBits = 2000;
   localparam logic [15:0] mseVal   = 16'(1 << csrMseBit);
   localparam logic [15:0] saeVal   = 16'(1 << csrSaeBit);
   localparam logic [15:0] clrVal   = 16'(1 << csrClrBit);
   localparam logic [15:0] rdoneVal = 16'(1 << csrRdoneBit);
   localparam logic [15:0] saVal    = 16'(1 << csrSaBit);

   logic                clk;
   logic                rst;
   logic [numLines-1:0] rxSerial;
   logic                csrWrite;
   logic [15:0]         csrWdata;
   logic [15:0]         csrRdata;
   logic                rbufRead;
   logic [15:0]         rbufData;
   logic                rbufRdone;
   logic                rbufSa;

   int          testErrors  = 0;
   int          errorCount  = 0;
   int          testsRun    = 0;
   int          testsFailed = 0;
   int          propFails;
   // Expected RBUF words in arrival order
   logic [15:0] expQ [$];

   dzRx i_dut (
      .clk       (clk),
      .rst       (rst),
      .rxSerial  (rxSerial),
      .csrWrite  (csrWrite),
      .csrWdata  (csrWdata),
      .csrRdata  (csrRdata),
      .rbufRead  (rbufRead),
      .rbufData  (rbufData),
      .rbufRdone (rbufRdone),
      .rbufSa    (rbufSa)
   );

   // 10 ns clock
   initial
   begin
      clk = 1'b0;
      forever
         #5 clk = ~clk;
   end

   initial
   begin
      #(watchdogBits * clksPerBit * 10);
      $display("Watchdog expired after %0d bit times, tests did not complete", watchdogBits);
      $display("Simulation finished: FAIL");
      $finish;
   end

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////

   task automatic checkValue(input string name, input logic [15:0] actual,
                             input logic [15:0] expected);
      if (actual !== expected)
      begin
         $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, actual, expected);
         testErrors++;
      end
   endtask

   // Expected word: DVAL, OVRE, FERR, PERR zero, line, character
   function automatic logic [15:0] rbufWord(input logic ovre, input logic ferr,
                                            input logic [scanBits-1:0] line,
                                            input logic [7:0] ch);
      logic [15:0] w;
      w = '0;
      w[rbufDvalBit] = 1'b1;
      w[rbufOvreBit] = ovre;
      w[rbufFerrBit] = ferr;
      w[rbufLineLsb +: scanBits] = line;
      w[7:0] = ch;
      return w;
   endfunction

   task automatic driveBit(input logic [scanBits-1:0] line, input logic value);
      rxSerial[line] <= value;
      repeat (clksPerBit)
         @(posedge clk);
   endtask

   // Start, 8 data LSB first, stop, then idle until readable (12 bit times)
   task automatic sendChar(input logic [scanBits-1:0] line, input logic [7:0] ch,
                           input logic goodStop);
      logic [7:0] bits;
      bits = ch;
      @(posedge clk);
      driveBit(line, 1'b0);
      for (int b = 0; b < 8; b++)
      begin
         driveBit(line, bits[0]);
         bits = bits >> 1;
      end
      driveBit(line, goodStop);
      driveBit(line, 1'b1);
      driveBit(line, 1'b1);
   endtask

   task automatic writeCsr(input logic [15:0] data);
      @(posedge clk);
      csrWrite <= 1'b1;
      csrWdata <= data;
      @(posedge clk);
      csrWrite <= 1'b0;
      csrWdata <= '0;
      repeat (2)
         @(posedge clk);
   endtask

   // Host read cycle, word sampled while rbufRead is high
   task automatic readRbuf(output logic [15:0] word);
      @(posedge clk);
      rbufRead <= 1'b1;
      @(negedge clk);
      word = rbufData;
      @(posedge clk);
      rbufRead <= 1'b0;
      // Pointer moves after the trailing edge, head one clock later
      repeat (3)
         @(posedge clk);
   endtask

   task automatic readExpected();
      logic [15:0] word;
      logic [15:0] expected;
      expected = expQ.pop_front();
      readRbuf(word);
      checkValue("rbufData", word, expected);
   endtask

   task automatic waitRdone(input int limit);
      int n;
      n = 0;
      while (!rbufRdone && n < limit)
      begin
         @(negedge clk);
         n++;
      end
      if (!rbufRdone)
      begin
         $display("RDONE did not rise within %0d clocks at %0t", limit, $time);
         testErrors++;
      end
   endtask

   task automatic finishTest(input string name);
      testsRun++;
      errorCount += testErrors;
      if (testErrors == 0)
         $display("Test %s: ok", name);
      else
      begin
         testsFailed++;
         $display("Test %s: %0d errors", name, testErrors);
      end
      testErrors = 0;
   endtask

   //////////////////////////////////////////////////
   // Tests
   //////////////////////////////////////////////////

   task automatic testResetIdle();
      @(negedge clk);
      checkValue("rbufRdone", 16'(rbufRdone), 16'd0);
      checkValue("rbufSa", 16'(rbufSa), 16'd0);
      checkValue("csrRdata", csrRdata, 16'd0);
      // Scanning off, character stays in the receiver
      sendChar(3'd0, 8'h5a, 1'b1);
      @(negedge clk);
      checkValue("rbufRdone", 16'(rbufRdone), 16'd0);
      // Let the held character in, then flush the silo
      writeCsr(mseVal);
      waitRdone(clksPerBit);
      writeCsr(mseVal | clrVal);
      @(negedge clk);
      checkValue("rbufRdone", 16'(rbufRdone), 16'd0);
      finishTest("reset and idle");
   endtask

   task automatic testEachLine();
      logic [7:0] ch;
      for (int i = 0; i < numLines; i++)
      begin
         ch = 8'($urandom);
         sendChar(scanBits'(i), ch, 1'b1);
         expQ.push_back(rbufWord(1'b0, 1'b0, scanBits'(i), ch));
      end
      while (expQ.size() > 0)
         readExpected();
      @(negedge clk);
      checkValue("rbufRdone", 16'(rbufRdone), 16'd0);
      finishTest("one character per line");
   endtask

   task automatic testFramingError();
      logic [7:0]  ch;
      logic [15:0] word;
      ch = 8'($urandom);
      sendChar(3'd3, ch, 1'b0);
      waitRdone(clksPerBit);
      readRbuf(word);
      checkValue("rbufData", word, rbufWord(1'b0, 1'b1, 3'd3, ch));
      finishTest("framing error");
   endtask

   task automatic testSiloAlarm();
      logic [7:0] ch;
      writeCsr(mseVal | saeVal);
      @(negedge clk);
      checkValue("csrRdata", csrRdata, mseVal | saeVal);
      for (int i = 0; i < alarmLevel; i++)
      begin
         ch = 8'($urandom);
         sendChar(scanBits'(i), ch, 1'b1);
         expQ.push_back(rbufWord(1'b0, 1'b0, scanBits'(i), ch));
         @(negedge clk);
         // Alarm only on the last one
         checkValue("rbufSa", 16'(rbufSa), 16'(i == alarmLevel - 1));
      end
      checkValue("csrRdata[SA]", 16'(csrRdata[csrSaBit]), 16'd1);
      readExpected();
      @(negedge clk);
      checkValue("rbufSa", 16'(rbufSa), 16'd0);
      checkValue("csrRdata[SA]", 16'(csrRdata[csrSaBit]), 16'd0);
      while (expQ.size() > 0)
         readExpected();
      writeCsr(mseVal);
      finishTest("silo alarm");
   endtask

   task automatic testOverrun();
      logic [7:0] sent [siloDepth + 1];
      for (int i = 0; i <= siloDepth; i++)
      begin
         sent[i] = 8'($urandom);
         sendChar(scanBits'(i), sent[i], 1'b1);
      end
      // 64th character is lost, the 65th takes its slot
      for (int i = 0; i < siloDepth - 1; i++)
         expQ.push_back(rbufWord(1'b0, 1'b0, scanBits'(i), sent[i]));
      expQ.push_back(rbufWord(1'b1, 1'b0, scanBits'(siloDepth), sent[siloDepth]));
      while (expQ.size() > 0)
         readExpected();
      @(negedge clk);
      checkValue("rbufRdone", 16'(rbufRdone), 16'd0);
      finishTest("overrun");
   endtask

   task automatic testClear();
      logic [7:0]  ch;
      logic [15:0] word;
      writeCsr(mseVal | saeVal);
      // Enough characters to raise the alarm
      for (int i = 0; i < alarmLevel; i++)
         sendChar(scanBits'(i), 8'($urandom), 1'b1);
      @(negedge clk);
      checkValue("rbufRdone", 16'(rbufRdone), 16'd1);
      checkValue("rbufSa", 16'(rbufSa), 16'd1);
      checkValue("csrRdata", csrRdata, mseVal | saeVal | rdoneVal | saVal);
      // SAE stays set, so only the clear can drop the alarm
      writeCsr(mseVal | saeVal | clrVal);
      @(negedge clk);
      checkValue("rbufRdone", 16'(rbufRdone), 16'd0);
      checkValue("rbufSa", 16'(rbufSa), 16'd0);
      checkValue("rbufData[DVAL]", 16'(rbufData[rbufDvalBit]), 16'd0);
      // Only the new character after the clear
      ch = 8'($urandom);
      sendChar(3'd5, ch, 1'b1);
      waitRdone(clksPerBit);
      readRbuf(word);
      checkValue("rbufData", word, rbufWord(1'b0, 1'b0, 3'd5, ch));
      @(negedge clk);
      checkValue("rbufRdone", 16'(rbufRdone), 16'd0);
      finishTest("clear");
   endtask

   //////////////////////////////////////////////////
   // Sequence
   //////////////////////////////////////////////////

   initial
   begin
      void'($urandom(32'h4fa9));
      rst      = 1'b1;
      rxSerial = '1;
      csrWrite = 1'b0;
      csrWdata = '0;
      rbufRead = 1'b0;
      repeat (4)
         @(posedge clk);
      rst <= 1'b0;
      repeat (2)
         @(posedge clk);
      testResetIdle();
      testEachLine();
      testFramingError();
      testSiloAlarm();
      testOverrun();
      testClear();
      propFails = i_dut.i_rbuf.i_props.depthFails + i_dut.i_rbuf.i_props.rdoneFails
                + i_dut.i_rbuf.i_props.clrFails + i_dut.i_rbuf.i_props.mseFails;
      $display("Tests %0d, with errors %0d, check errors %0d, assertion failures %0d",
               testsRun, testsFailed, errorCount, propFails);
      if (errorCount == 0 && propFails == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: dzRx_properties.sv
// Concurrent checks on the receive silo; attached to every dzRbuf through the bind below
`timescale 1ns/1ps
`default_nettype none

module dzRbufProperties import dzPkg::*; (
   input wire                 clk,
   input wire                 rst,
   input wire                 csrMse,
   input wire [depthBits-1:0] depth,
   input wire [ptrBits-1:0]   rdPtr,
   input wire [ptrBits-1:0]   wrPtr,
   input wire                 rbufRdone,
   input wire [15:0]          uartRxData,
   input wire [numLines-1:0]  uartRxClr
);

   // Failures per property
   int depthFails = 0;
   int rdoneFails = 0;
   int clrFails   = 0;
   int mseFails   = 0;

   //////////////////////////////////////////////////
   // Silo occupancy
   //////////////////////////////////////////////////

   depthLimit: assert property (@(posedge clk) disable iff (rst)
      depth <= depthBits'(siloDepth))
   else
   begin
      $error("silo depth %0d above %0d", depth, siloDepth);
      depthFails++;
   end

   // RDONE against the pointer view of occupancy
   rdoneMatch: assert property (@(posedge clk) disable iff (rst)
      rbufRdone == ((wrPtr != rdPtr) || (depth == depthBits'(siloDepth))))
   else
   begin
      $error("rbufRdone %b with pointers %0d/%0d, depth %0d",
             rbufRdone, wrPtr, rdPtr, depth);
      rdoneFails++;
   end

   //////////////////////////////////////////////////
   // Receiver side
   //////////////////////////////////////////////////

   // At most one clear, and only for the line in the receive word
   clrOneHot: assert property (@(posedge clk) disable iff (rst)
      uartRxClr == '0
      || uartRxClr == (numLines'(1) << uartRxData[rbufLineLsb +: scanBits]))
   else
   begin
      $error("uartRxClr %b does not match scanned line %0d",
             uartRxClr, uartRxData[rbufLineLsb +: scanBits]);
      clrFails++;
   end

   // Scanning off means the silo does not grow
   noWriteIdle: assert property (@(posedge clk) disable iff (rst)
      !csrMse |=> depth <= $past(depth))
   else
   begin
      $error("silo depth grew with MSE low");
      mseFails++;
   end

endmodule

bind dzRbuf dzRbufProperties i_props (
   .clk        (clk),
   .rst        (rst),
   .csrMse     (csrMse),
   .depth      (depth),
   .rdPtr      (rdPtr),
   .wrPtr      (wrPtr),
   .rbufRdone  (rbufRdone),
   .uartRxData (uartRxData),
   .uartRxClr  (uartRxClr)
);

`default_nettype wire

// File: dzScanner.sv
// Line scanner; steps through the receivers and presents the scanned line's receive word
`timescale 1ns/1ps
`default_nettype none

module dzScanner import dzPkg::*; (
   input  wire                     clk,
   input  wire                     rst,
   input  wire                     csrMse,
   input  wire [numLines*8-1:0]    rxChar,
   input  wire [numLines-1:0]      rxFerr,
   input  wire [numLines-1:0]      rxFull,
   output logic [scanBits-1:0]     scan,
   output logic [15:0]             uartRxData,
   output logic                    uartRxFull
);

   //////////////////////////////////////////////////
   // Scan counter
   //////////////////////////////////////////////////

   // Free running while MSE set, parked on line 0 otherwise
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         scan <= '0;
      else if (!csrMse)
         scan <= '0;
      else
         scan <= scan + 1'b1;
   end

   //////////////////////////////////////////////////
   // Receive word of the scanned line
   //////////////////////////////////////////////////

   always_comb
   begin
      uartRxData = '0;
      // Character from the selected receiver
      uartRxData[7:0] = rxChar[{scan, 3'b000} +: 8];
      // Line number
      uartRxData[rbufLineLsb +: scanBits] = scan;
      uartRxData[rbufFerrBit] = rxFerr[scan];
      // No parity support
      uartRxData[rbufPerrBit] = 1'b0;
   end

   // Full flag of the same line
   assign uartRxFull = rxFull[scan];

endmodule

`default_nettype wire

// File: dzUartRx.sv
// Single-line 8N1 serial receiver; one instance per line, full flag cleared by the scanner
`timescale 1ns/1ps
`default_nettype none

module dzUartRx import dzPkg::*; (
   input  wire        clk,
   input  wire        rst,
   input  wire        rxSerial,
   input  wire        rxClr,
   output logic [7:0] rxChar,
   output logic       rxFerr,
   output logic       rxFull
);

   //////////////////////////////////////////////////
   // Input synchronizer and start edge
   //////////////////////////////////////////////////

   // Bits 0 and 1 synchronize, bit 2 is the previous sample
   logic [2:0]          syncReg;
   logic                rxIn;
   logic                fallEdge;
   rxState_t            state;
   logic [tickBits-1:0] tick;
   logic [2:0]          bitCnt;
   logic [7:0]          shiftReg;
   logic                bitDone;
   logic                midStart;

   assign rxIn     = syncReg[1];
   assign fallEdge = syncReg[2] & ~syncReg[1];

   // Full bit period elapsed
   assign bitDone  = (tick == tickBits'(clksPerBit - 1));
   // Half bit into the start bit
   assign midStart = (tick == tickBits'(clksPerBit / 2 - 1));

   //////////////////////////////////////////////////
   // Receiver FSM
   //////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         syncReg <= '1;
         state   <= rxIdle;
         tick    <= '0;
         bitCnt  <= '0;
         rxFull  <= 1'b0;
      end
      else
      begin
         syncReg <= {syncReg[1:0], rxSerial};
         // Scanner took the character
         if (rxClr)
            rxFull <= 1'b0;
         case (state)
            rxIdle:
               if (fallEdge)
               begin
                  tick  <= '0;
                  state <= rxStart;
               end
            rxStart:
               if (midStart)
               begin
                  // Glitch if the line went back high
                  tick   <= '0;
                  bitCnt <= '0;
                  state  <= rxIn ? rxIdle : rxData;
               end
               else
                  tick <= tick + 1'b1;
            rxData:
               if (bitDone)
               begin
                  tick   <= '0;
                  bitCnt <= bitCnt + 1'b1;
                  if (bitCnt == 3'd7)
                     state <= rxStop;
               end
               else
                  tick <= tick + 1'b1;
            rxStop:
               if (bitDone)
               begin
                  // New character wins over a same-cycle clear
                  tick   <= '0;
                  rxFull <= 1'b1;
                  state  <= rxIdle;
               end
               else
                  tick <= tick + 1'b1;
            default:
               state <= rxIdle;
         endcase
      end
   end

   // Data path, LSB arrives first
   always_ff @(posedge clk)
   begin
      if (state == rxData && bitDone)
         shiftReg <= {rxIn, shiftReg[7:1]};
      if (state == rxStop && bitDone)
      begin
         rxChar <= shiftReg;
         // Stop bit must be high
         rxFerr <= ~rxIn;
      end
   end

endmodule

`default_nettype wire

// File: files.f
dzPkg.sv
dzUartRx.sv
dzScanner.sv
dzCsr.sv
dzRbuf.sv
dzRx.sv
dzRx_properties.sv
dzRxTb.sv
